//--- design/disp_pkg.sv
`default_nettype none

package disp_pkg;

  // Square matrix, rows and columns alike.
  localparam int MATRIX_DIM = 8;
  localparam int PIXEL_COUNT = MATRIX_DIM * MATRIX_DIM;

  // Bit 2 is red, bit 1 green, bit 0 blue.
  // Listed so that a plain increment walks through all eight colors.
  typedef enum logic [2:0] {
    black   = 3'd0,
    blue    = 3'd1,
    green   = 3'd2,
    cyan    = 3'd3,
    red     = 3'd4,
    magenta = 3'd5,
    yellow  = 3'd6,
    white   = 3'd7
  } color_t;

endpackage

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // One editor command per cycle.
  typedef enum logic [1:0] {
    cmd_none   = 2'd0,
    cmd_up     = 2'd1,
    cmd_down   = 2'd2,
    cmd_select = 2'd3
  } cmd_t;

  // Debounce machine for a single button.
  typedef enum logic [1:0] {
    btn_idle   = 2'd0, // Released and stable.
    btn_settle = 2'd1, // Pressed, waiting for the level to hold.
    btn_held   = 2'd2  // Pressed and stable, waiting for release.
  } btn_state_t;

endpackage

`default_nettype wire

//--- design/reset_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module reset_conditioner #(
  parameter int RESET_STAGES = 4
) (
  input  logic rcclk,
  input  logic rst_n,
  output logic sync_rst_n
);

  logic [RESET_STAGES-1:0] stage;

  // Set at once by the pin, then drained one stage per clock.
  always_ff @(posedge rcclk or negedge rst_n) begin
    if (!rst_n) begin
      stage <= '1;
    end else begin
      stage <= {stage[RESET_STAGES-2:0], 1'b0};
    end
  end

  assign sync_rst_n = ~stage[RESET_STAGES-1];

endmodule

`default_nettype wire

//--- design/button_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
  parameter int DEBOUNCE_CYCLES = 50000
) (
  input  logic rcclk,
  input  logic rst_n,
  input  logic button,
  output logic press
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

  logic [1:0] sync_q;
  logic btn_level;
  logic [CNT_W-1:0] cnt, cnt_next;
  ctrl_pkg::btn_state_t state, state_next;

  assign btn_level = sync_q[1];

  always_comb begin
    state_next = state;
    cnt_next = '0;
    case (state)
      ctrl_pkg::btn_idle: begin
        if (btn_level) state_next = ctrl_pkg::btn_settle;
      end
      ctrl_pkg::btn_settle: begin
        if (!btn_level) begin
          state_next = ctrl_pkg::btn_idle; // Bounce, start over.
        end else if (cnt == CNT_LAST) begin
          state_next = ctrl_pkg::btn_held;
        end else begin
          cnt_next = cnt + 1'b1;
        end
      end
      ctrl_pkg::btn_held: begin
        // Release must hold just as long before the button re-arms.
        if (!btn_level) begin
          if (cnt == CNT_LAST) state_next = ctrl_pkg::btn_idle;
          else cnt_next = cnt + 1'b1;
        end
      end
      default: state_next = ctrl_pkg::btn_idle;
    endcase
  end

  always_ff @(posedge rcclk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
      state <= ctrl_pkg::btn_idle;
      cnt <= '0;
      press <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], button};
      state <= state_next;
      cnt <= cnt_next;
      press <= (state == ctrl_pkg::btn_settle) && (state_next == ctrl_pkg::btn_held);
    end
  end

endmodule

`default_nettype wire

//--- design/pixel_editor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_editor (
  input  logic rcclk,
  input  logic rst_n,
  input  logic up_press,
  input  logic down_press,
  input  logic sel_press,
  input  logic [2:0] next_col,
  output logic [5:0] cursor,
  output logic [disp_pkg::MATRIX_DIM-1:0] col_red,
  output logic [disp_pkg::MATRIX_DIM-1:0] col_green,
  output logic [disp_pkg::MATRIX_DIM-1:0] col_blue
);

  ctrl_pkg::cmd_t cmd;
  disp_pkg::color_t frame [disp_pkg::PIXEL_COUNT];
  disp_pkg::color_t next_color;

  // Up beats down, down beats select.
  always_comb begin
    if (up_press) cmd = ctrl_pkg::cmd_up;
    else if (down_press) cmd = ctrl_pkg::cmd_down;
    else if (sel_press) cmd = ctrl_pkg::cmd_select;
    else cmd = ctrl_pkg::cmd_none;
  end

  assign next_color = disp_pkg::color_t'(frame[cursor] + 3'd1); // Wraps white to black.

  always_ff @(posedge rcclk or negedge rst_n) begin
    if (!rst_n) begin
      cursor <= 6'd0;
      for (int i = 0; i < disp_pkg::PIXEL_COUNT; i++) begin
        frame[i] <= disp_pkg::black;
      end
    end else begin
      case (cmd)
        ctrl_pkg::cmd_up:     cursor <= cursor + 6'd1;
        ctrl_pkg::cmd_down:   cursor <= cursor - 6'd1;
        ctrl_pkg::cmd_select: frame[cursor] <= next_color;
        default: ;
      endcase
    end
  end

  // Pixel index is row * 8 + column, so a column is every eighth entry.
  always_comb begin
    disp_pkg::color_t pix;
    pix = disp_pkg::black;
    for (int r = 0; r < disp_pkg::MATRIX_DIM; r++) begin
      pix = frame[r * disp_pkg::MATRIX_DIM + int'(next_col)];
      col_red[r] = pix[2];
      col_green[r] = pix[1];
      col_blue[r] = pix[0];
    end
  end

endmodule

`default_nettype wire

//--- design/matrix_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scanner #(
  parameter int SCAN_DIV = 1024
) (
  input  logic rcclk,
  input  logic rst_n,
  output logic [2:0] next_col,
  input  logic [disp_pkg::MATRIX_DIM-1:0] col_red,
  input  logic [disp_pkg::MATRIX_DIM-1:0] col_green,
  input  logic [disp_pkg::MATRIX_DIM-1:0] col_blue,
  output logic [disp_pkg::MATRIX_DIM-1:0] d_c,
  output logic [disp_pkg::MATRIX_DIM-1:0] d_r,
  output logic [disp_pkg::MATRIX_DIM-1:0] d_g,
  output logic [disp_pkg::MATRIX_DIM-1:0] d_b
);

  localparam int DIV_W = $clog2(SCAN_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

  logic [DIV_W-1:0] div_cnt;
  logic div_wrap;
  logic [disp_pkg::MATRIX_DIM-1:0] col_onehot;

  assign div_wrap = (div_cnt == DIV_LAST);

  always_comb begin
    col_onehot = '0;
    col_onehot[next_col] = 1'b1;
  end

  always_ff @(posedge rcclk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      next_col <= 3'd0;
      d_c <= '0; // Matrix dark until the first wrap.
      d_r <= '0;
      d_g <= '0;
      d_b <= '0;
    end else begin
      if (div_wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      if (div_wrap) begin
        // Column enable and row data switch together.
        d_c <= col_onehot;
        d_r <= col_red;
        d_g <= col_green;
        d_b <= col_blue;
        next_col <= next_col + 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_top #(
  parameter int RESET_STAGES = 4,
  parameter int DEBOUNCE_CYCLES = 50000,
  parameter int SCAN_DIV = 1024
) (
  input  logic rcclk,
  input  logic rst_n,
  input  logic up_button,
  input  logic down_button,
  input  logic select_button,
  output logic [5:0] led,
  output logic [7:0] d_c,
  output logic [7:0] d_r,
  output logic [7:0] d_g,
  output logic [7:0] d_b
);

  logic sync_rst_n;
  logic up_press, down_press, sel_press;
  logic [2:0] next_col;
  logic [7:0] col_red, col_green, col_blue;

  reset_conditioner #(.RESET_STAGES(RESET_STAGES)) u_reset_cond (
    .rcclk(rcclk),
    .rst_n(rst_n),
    .sync_rst_n(sync_rst_n)
  );

  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_up_btn (
    .rcclk(rcclk),
    .rst_n(sync_rst_n),
    .button(up_button),
    .press(up_press)
  );

  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_down_btn (
    .rcclk(rcclk),
    .rst_n(sync_rst_n),
    .button(down_button),
    .press(down_press)
  );

  button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_sel_btn (
    .rcclk(rcclk),
    .rst_n(sync_rst_n),
    .button(select_button),
    .press(sel_press)
  );

  // LEDs show the cursor index directly.
  pixel_editor u_editor (
    .rcclk(rcclk),
    .rst_n(sync_rst_n),
    .up_press(up_press),
    .down_press(down_press),
    .sel_press(sel_press),
    .next_col(next_col),
    .cursor(led),
    .col_red(col_red),
    .col_green(col_green),
    .col_blue(col_blue)
  );

  matrix_scanner #(.SCAN_DIV(SCAN_DIV)) u_scanner (
    .rcclk(rcclk),
    .rst_n(sync_rst_n),
    .next_col(next_col),
    .col_red(col_red),
    .col_green(col_green),
    .col_blue(col_blue),
    .d_c(d_c),
    .d_r(d_r),
    .d_g(d_g),
    .d_b(d_b)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  // Free-running clock, low for the first half period.
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- testbench/matrix_assert.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_assert (
  input logic rcclk,
  input logic rst_n,
  input logic [7:0] d_c,
  input logic [7:0] d_r,
  input logic [7:0] d_g,
  input logic [7:0] d_b,
  input logic press,
  input ctrl_pkg::btn_state_t state
);

  int unsigned fail_count = 0;

  col_onehot_a: assert property (@(posedge rcclk) disable iff (!rst_n) $onehot0(d_c))
    else begin
      $error("column enable has several bits set: %h", d_c);
      fail_count++;
    end

  // A dark column must not light any row.
  dark_rows_a: assert property (@(posedge rcclk) disable iff (!rst_n)
    (d_c == 8'h00) |-> (d_r == 8'h00 && d_g == 8'h00 && d_b == 8'h00))
    else begin
      $error("row drive active while no column is enabled");
      fail_count++;
    end

  press_single_a: assert property (@(posedge rcclk) disable iff (!rst_n) press |=> !press)
    else begin
      $error("press pulse lasted more than one cycle");
      fail_count++;
    end

  press_entry_a: assert property (@(posedge rcclk) disable iff (!rst_n)
    press |-> (state == ctrl_pkg::btn_held) && ($past(state) == ctrl_pkg::btn_settle))
    else begin
      $error("press pulse without entry into the held state");
      fail_count++;
    end

endmodule

// The scanner has no debounce machine, so its press side stays idle.
bind matrix_scanner matrix_assert scan_chk (
  .rcclk(rcclk),
  .rst_n(rst_n),
  .d_c(d_c),
  .d_r(d_r),
  .d_g(d_g),
  .d_b(d_b),
  .press(1'b0),
  .state(ctrl_pkg::btn_idle)
);

bind button_conditioner matrix_assert btn_chk (
  .rcclk(rcclk),
  .rst_n(rst_n),
  .d_c(8'h00),
  .d_r(8'h00),
  .d_g(8'h00),
  .d_b(8'h00),
  .press(press),
  .state(state)
);

`default_nettype wire

//--- testbench/matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_tb;

  localparam int RESET_STAGES = 4;
  localparam int DEBOUNCE_CYCLES = 8;
  localparam int SCAN_DIV = 4;
  localparam int HOLD_CYCLES = DEBOUNCE_CYCLES + 6; // Per half of a press.
  localparam int BOUNCE_CYCLES = 2;
  localparam int NUM_PRESSES = 300;
  localparam int RESET_AT = 150;
  localparam int FIRST_WRAP = RESET_STAGES + SCAN_DIV;
  localparam int TIMEOUT_CYCLES = NUM_PRESSES * HOLD_CYCLES * 2 + 200;
  localparam int BTN_UP = 0;
  localparam int BTN_DOWN = 1;
  localparam int BTN_SELECT = 2;

  logic rcclk;
  logic rst_n;
  logic up_button;
  logic down_button;
  logic select_button;
  logic [5:0] led;
  logic [7:0] d_c;
  logic [7:0] d_r;
  logic [7:0] d_g;
  logic [7:0] d_b;

  logic [5:0] model_cursor;
  logic [2:0] model_frame [64]; // Bit 2 red, bit 1 green, bit 0 blue.

  int errors;
  int checks;
  int cycle_count;
  int since_reset;
  int since_capture;
  int unsigned assert_fails;
  logic scan_on;
  logic settled;
  logic fresh; // Current column was latched from a settled frame.
  logic [2:0] cur_col;
  logic [2:0] exp_col;

  tb_clock #(.PERIOD_NS(4.0)) u_clock (.clk(rcclk));

  matrix_top #(
    .RESET_STAGES(RESET_STAGES),
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
    .SCAN_DIV(SCAN_DIV)
  ) UUT (
    .rcclk(rcclk),
    .rst_n(rst_n),
    .up_button(up_button),
    .down_button(down_button),
    .select_button(select_button),
    .led(led),
    .d_c(d_c),
    .d_r(d_r),
    .d_g(d_g),
    .d_b(d_b)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  function automatic logic [7:0] model_plane(input logic [2:0] col, input logic [1:0] bit_idx);
    logic [7:0] plane;
    plane = 8'h00;
    for (int r = 0; r < 8; r++) begin
      plane[r] = model_frame[r * 8 + int'(col)][bit_idx];
    end
    return plane;
  endfunction

  task automatic check_outputs();
    if (rst_n) since_reset++;
    if (settled) check_value("led", 32'(led), 32'(model_cursor));
    if (!scan_on && rst_n && since_reset == FIRST_WRAP) begin
      scan_on = 1'b1;
      since_capture = SCAN_DIV - 1;
    end
    if (!scan_on) begin
      check_value("d_c", 32'(d_c), 32'd0); // Dark until the first wrap.
      check_value("d_r", 32'(d_r), 32'd0);
      check_value("d_g", 32'(d_g), 32'd0);
      check_value("d_b", 32'(d_b), 32'd0);
    end else begin
      since_capture++;
      if (since_capture == SCAN_DIV) begin
        since_capture = 0;
        cur_col = exp_col;
        exp_col = exp_col + 3'd1;
        fresh = settled;
      end
      check_value("d_c", 32'(d_c), 32'(8'b1 << cur_col));
      if (fresh) begin
        check_value("d_r", 32'(d_r), 32'(model_plane(cur_col, 2'd2)));
        check_value("d_g", 32'(d_g), 32'(model_plane(cur_col, 2'd1)));
        check_value("d_b", 32'(d_b), 32'(model_plane(cur_col, 2'd0)));
      end
    end
  endtask

  task automatic tick();
    @(negedge rcclk);
    check_outputs();
  endtask

  task automatic drive_buttons(input int which, input logic level);
    up_button = (which == BTN_UP) && level;
    down_button = (which == BTN_DOWN) && level;
    select_button = (which == BTN_SELECT) && level;
  endtask

  task automatic apply_reset();
    model_cursor = 6'd0;
    for (int i = 0; i < 64; i++) begin
      model_frame[i] = 3'd0;
    end
    scan_on = 1'b0;
    settled = 1'b1;
    fresh = 1'b0;
    cur_col = 3'd0;
    exp_col = 3'd0;
    since_reset = 0;
    rst_n = 1'b0;
    repeat (4) tick();
    rst_n = 1'b1;
    since_reset = 0;
    repeat (RESET_STAGES + 2) tick(); // Let the conditioners leave reset.
  endtask

  task automatic press_button(input int which);
    logic level;
    settled = 1'b0;
    fresh = 1'b0;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      if (i < BOUNCE_CYCLES) level = 1'($urandom % 2);
      else level = 1'b1;
      drive_buttons(which, level);
      tick();
    end
    // One step per press whatever the bounce did.
    case (which)
      BTN_UP: model_cursor = model_cursor + 6'd1;
      BTN_DOWN: model_cursor = model_cursor - 6'd1;
      default: model_frame[model_cursor] = model_frame[model_cursor] + 3'd1;
    endcase
    check_value("led", 32'(led), 32'(model_cursor));
    settled = 1'b1;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      drive_buttons(which, 1'b0);
      tick();
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge rcclk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h95b7_a7f1));
    errors = 0;
    checks = 0;
    rst_n = 1'b0;
    up_button = 1'b0;
    down_button = 1'b0;
    select_button = 1'b0;
    apply_reset();
    for (int n = 0; n < NUM_PRESSES; n++) begin
      press_button(int'($urandom % 3));
      if (n == RESET_AT) begin
        rst_n = 1'b0;
        #1;
        // Reset clears the outputs without waiting for a clock edge.
        check_value("led", 32'(led), 32'd0);
        check_value("d_c", 32'(d_c), 32'd0);
        check_value("d_r", 32'(d_r), 32'd0);
        check_value("d_g", 32'(d_g), 32'd0);
        check_value("d_b", 32'(d_b), 32'd0);
        apply_reset();
      end
    end
    assert_fails = UUT.u_scanner.scan_chk.fail_count + UUT.u_up_btn.btn_chk.fail_count +
                   UUT.u_down_btn.btn_chk.fail_count + UUT.u_sel_btn.btn_chk.fail_count;
    $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
design/disp_pkg.sv
design/ctrl_pkg.sv
design/reset_conditioner.sv
design/button_conditioner.sv
design/pixel_editor.sv
design/matrix_scanner.sv
design/matrix_top.sv
testbench/tb_clock.sv
testbench/matrix_assert.sv
testbench/matrix_tb.sv

//--- Makefile
TOP = matrix_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module matrix_top design/disp_pkg.sv design/ctrl_pkg.sv \
		design/reset_conditioner.sv design/button_conditioner.sv design/pixel_editor.sv \
		design/matrix_scanner.sv design/matrix_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
